// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run ifu_tb and check the log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module ifu_tb --Mdir obj_dir -o ifu_sim
	./obj_dir/ifu_sim +verilator+error+limit+1000 | tee sim.log
	grep -qx "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
+incdir+logic
logic/ifu_pkg.sv
logic/refill_fsm.sv
logic/beat_counter.sv
logic/icache_store.sv
logic/pc_steer.sv
logic/ifu_top.sv
tb/ifu_checker.sv
tb/ifu_tb.sv

// File: logic/beat_counter.sv
`timescale 1ns/1ps
`default_nettype none

module beat_counter (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  step_i,
  output ifu_pkg::word_t word_o,
  output logic       beat_done_o
);

  ifu_pkg::word_t count_q;

  // steps once per stored beat and wraps back to word 0 after the line
  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else if (step_i) begin
      count_q <= count_q + ifu_pkg::word_t'(1);
    end
  end

  assign word_o = count_q;

  // high while the next beat to arrive is the last word of the line
  assign beat_done_o = (count_q == '1);

endmodule

`default_nettype wire

// File: logic/icache_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifu_params.svh"

module icache_store (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire ifu_pkg::addr_t pc_i,
  input  wire logic           fill_we_i,
  input  wire ifu_pkg::word_t fill_word_i,
  input  wire logic           fill_last_i,
  input  wire ifu_pkg::inst_t rdata_i,
  input  wire logic           flush_i,
  output logic                hit_o,
  output ifu_pkg::inst_t      inst_o
);

  localparam int SETS  = 1 << `IFU_SET_BITS;
  localparam int WORDS = 1 << `IFU_LINE_BITS;
  localparam int SET_LSB = `IFU_BYTE_BITS + `IFU_LINE_BITS;

  ifu_pkg::inst_t data_q [SETS][WORDS];
  ifu_pkg::tag_t  tag_q  [SETS];
  logic [SETS-1:0] valid_q;

  ifu_pkg::tag_t  pc_tag;
  ifu_pkg::set_t  pc_set;
  ifu_pkg::word_t pc_word;

  // ************************************************************
  // address split
  // ************************************************************
  assign pc_tag  = pc_i[`IFU_ADDR_W-1 -: `IFU_TAG_W];
  assign pc_set  = pc_i[SET_LSB +: `IFU_SET_BITS];
  assign pc_word = pc_i[`IFU_BYTE_BITS +: `IFU_LINE_BITS];

  // ************************************************************
  // arrays
  // ************************************************************
  always_ff @(posedge clk) begin
    if (fill_we_i) begin
      data_q[pc_set][fill_word_i] <= rdata_i;
    end
    if (fill_we_i && fill_last_i) begin
      tag_q[pc_set] <= pc_tag; // tag goes in with the beat that completes the line
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (flush_i) begin
      // fence.i drops every line, the next fetch goes to the bus
      valid_q <= '0;
    end else if (fill_we_i && fill_last_i) begin
      valid_q[pc_set] <= 1'b1;
    end
  end

  // lookup is purely combinational so a hit can hand over in the same cycle
  assign hit_o  = valid_q[pc_set] && (tag_q[pc_set] == pc_tag);
  assign inst_o = data_q[pc_set][pc_word];

endmodule

`default_nettype wire

// File: logic/ifu_params.svh
`ifndef IFU_PARAMS_SVH
`define IFU_PARAMS_SVH

// datapath widths
`define IFU_ADDR_W 32
`define IFU_DATA_W 32

// L1I geometry, 4 sets of 2-word lines
`define IFU_SET_BITS 2
`define IFU_LINE_BITS 1
`define IFU_BYTE_BITS 2
`define IFU_TAG_W (`IFU_ADDR_W - `IFU_SET_BITS - `IFU_LINE_BITS - `IFU_BYTE_BITS)

`define IFU_PC_INIT 32'h8000_0000

// ************************************************************
// RV32 opcodes that steer the fetch
// ************************************************************
`define IFU_OP_JAL 7'b1101111
`define IFU_OP_JALR 7'b1100111
`define IFU_OP_BRANCH 7'b1100011
`define IFU_OP_SYSTEM 7'b1110011
`define IFU_OP_LOAD 7'b0000011

// fence.i with rd, rs1 and imm all zero
`define IFU_INST_FENCE_I 32'h0000_100f

`endif

// File: logic/ifu_pkg.sv
`default_nettype none

`include "ifu_params.svh"

package ifu_pkg;

  // byte address, also used for the PC
  typedef logic [`IFU_ADDR_W-1:0] addr_t;

  // instruction word, same width as the read bus data
  typedef logic [`IFU_DATA_W-1:0] inst_t;

  // ************************************************************
  // cache address fields
  // ************************************************************
  typedef logic [`IFU_TAG_W-1:0] tag_t;
  typedef logic [`IFU_SET_BITS-1:0] set_t;
  typedef logic [`IFU_LINE_BITS-1:0] word_t;

  // line refill sequencing
  typedef enum logic [1:0] {
    R_IDLE,
    R_REQ,
    R_WAIT,
    R_FILL
  } refill_state_t;

endpackage

`default_nettype wire

// File: logic/ifu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifu_params.svh"

module ifu_top (
  input  wire logic           clk,
  input  wire logic           rst,
  output ifu_pkg::addr_t      araddr_o,
  output logic                arvalid_o,
  input  wire ifu_pkg::inst_t rdata_i,
  input  wire logic           rvalid_i,
  input  wire ifu_pkg::addr_t npc_i,
  input  wire logic           prev_valid_i,
  input  wire logic           pc_change_i,
  input  wire logic           pc_retire_i,
  output ifu_pkg::inst_t      inst_o,
  output ifu_pkg::addr_t      pc_o,
  output logic                valid_o,
  output logic                ready_o,
  input  wire logic           next_ready_i,
  output logic                bad_speculation_o
);

  localparam ifu_pkg::addr_t LINE_MASK =
    ifu_pkg::addr_t'((1 << (`IFU_LINE_BITS + `IFU_BYTE_BITS)) - 1);

  ifu_pkg::addr_t fill_pc_q;
  ifu_pkg::addr_t lookup_pc;
  ifu_pkg::word_t fill_word;
  logic hit, fill_we, beat_done, busy, flush;

  // the PC may be redirected mid refill, so the line being filled is held
  always_ff @(posedge clk) begin
    if (!busy) begin
      fill_pc_q <= pc_o;
    end
  end

  assign lookup_pc = busy ? fill_pc_q : pc_o;
  assign araddr_o  = (lookup_pc & ~LINE_MASK) + (ifu_pkg::addr_t'(fill_word) << 2);
  assign ready_o   = !valid_o;

  refill_fsm u_refill_fsm (
    .clk, .rst, .hit_i(hit), .rvalid_i, .beat_done_i(beat_done),
    .arvalid_o, .fill_we_o(fill_we), .busy_o(busy)
  );

  beat_counter u_beat_counter (
    .clk, .rst, .step_i(fill_we), .word_o(fill_word), .beat_done_o(beat_done)
  );

  icache_store u_icache_store (
    .clk, .rst, .pc_i(lookup_pc), .fill_we_i(fill_we), .fill_word_i(fill_word),
    .fill_last_i(beat_done), .rdata_i, .flush_i(flush), .hit_o(hit), .inst_o
  );

  // no hand-over while a refill is still in flight
  pc_steer u_pc_steer (
    .clk, .rst, .inst_i(inst_o), .hit_i(hit && !busy), .next_ready_i, .prev_valid_i,
    .pc_change_i, .pc_retire_i, .npc_i, .pc_o, .valid_o, .flush_o(flush),
    .bad_speculation_o
  );

endmodule

`default_nettype wire

// File: logic/pc_steer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifu_params.svh"

module pc_steer (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire ifu_pkg::inst_t inst_i,
  input  wire logic           hit_i,
  input  wire logic           next_ready_i,
  input  wire logic           prev_valid_i,
  input  wire logic           pc_change_i,
  input  wire logic           pc_retire_i,
  input  wire ifu_pkg::addr_t npc_i,
  output ifu_pkg::addr_t      pc_o,
  output logic                valid_o,
  output logic                flush_o,
  output logic                bad_speculation_o
);

  ifu_pkg::addr_t pc_q;
  ifu_pkg::addr_t btb_q;     // last taken target reported by the back end
  ifu_pkg::addr_t spec_pc_q; // target we guessed, checked at the next report
  logic btb_valid_q;
  logic spec_q;
  logic stall_q;             // waiting on a report for a branch or a load

  logic [6:0] opcode;
  logic is_branch;
  logic is_load;
  logic report;
  logic fire;
  logic predict;
  logic good_speculation;

  // ************************************************************
  // classification of the instruction at the PC
  // ************************************************************
  assign opcode = inst_i[6:0];
  assign is_branch = (opcode == `IFU_OP_JAL) || (opcode == `IFU_OP_JALR) ||
                     (opcode == `IFU_OP_BRANCH) || (opcode == `IFU_OP_SYSTEM);
  assign is_load = (opcode == `IFU_OP_LOAD);

  assign report = prev_valid_i && (pc_change_i || pc_retire_i);
  assign bad_speculation_o = report && spec_q && (npc_i != spec_pc_q);
  assign good_speculation  = report && spec_q && (npc_i == spec_pc_q);

  assign valid_o = hit_i && !stall_q;
  assign fire    = valid_o && next_ready_i && !bad_speculation_o; // a wrong guess kills the transfer
  assign predict = fire && is_branch && btb_valid_q && !spec_q;
  assign flush_o = fire && (inst_i == `IFU_INST_FENCE_I);
  assign pc_o    = pc_q;

  // ************************************************************
  // PC and control state
  // ************************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q        <= `IFU_PC_INIT;
      btb_valid_q <= 1'b0;
      spec_q      <= 1'b0;
      stall_q     <= 1'b0;
    end else begin
      if (prev_valid_i && pc_change_i) begin
        btb_valid_q <= 1'b1;
      end
      if (bad_speculation_o) begin
        // anything fetched past the guess is wrong path, stalls included
        pc_q    <= npc_i;
        spec_q  <= 1'b0;
        stall_q <= 1'b0;
      end else begin
        if (good_speculation) begin
          spec_q <= 1'b0;
        end else if (report && stall_q) begin
          pc_q    <= npc_i;
          stall_q <= 1'b0;
        end
        if (fire) begin
          if (predict) begin
            pc_q   <= btb_q;
            spec_q <= 1'b1;
          end else if (is_branch || is_load) begin
            stall_q <= 1'b1;
          end else begin
            pc_q <= pc_q + ifu_pkg::addr_t'(4);
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (prev_valid_i && pc_change_i) begin
      btb_q <= npc_i;
    end
    if (predict) begin
      spec_pc_q <= btb_q; // btb may be overwritten before the check
    end
  end

endmodule

`default_nettype wire

// File: logic/refill_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module refill_fsm (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic hit_i,
  input  wire logic rvalid_i,
  input  wire logic beat_done_i,
  output logic      arvalid_o,
  output logic      fill_we_o,
  output logic      busy_o
);

  ifu_pkg::refill_state_t state_q;
  ifu_pkg::refill_state_t state_d;

  // ************************************************************
  // next state
  // ************************************************************
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ifu_pkg::R_IDLE: begin
        if (!hit_i) begin
          state_d = ifu_pkg::R_REQ;
        end
      end
      ifu_pkg::R_REQ: begin
        if (rvalid_i) begin
          // the counter already points at the last word of the line
          if (beat_done_i) begin
            state_d = ifu_pkg::R_FILL;
          end else begin
            state_d = ifu_pkg::R_WAIT;
          end
        end
      end
      ifu_pkg::R_WAIT: begin
        state_d = ifu_pkg::R_REQ; // request is low for this one cycle between beats
      end
      ifu_pkg::R_FILL: begin
        // valid and tag were written with the last beat
        state_d = ifu_pkg::R_IDLE;
      end
      default: begin
        state_d = ifu_pkg::R_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ifu_pkg::R_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ************************************************************
  // outputs
  // ************************************************************
  assign arvalid_o = (state_q == ifu_pkg::R_REQ);
  assign fill_we_o = (state_q == ifu_pkg::R_REQ) && rvalid_i; // a beat to store
  assign busy_o    = (state_q != ifu_pkg::R_IDLE);

endmodule

`default_nettype wire

// File: tb/ifu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_checker (
  input wire logic           clk,
  input wire logic           rst,
  input wire logic           valid_o,
  input wire logic           ready_o,
  input wire logic           arvalid_o,
  input wire ifu_pkg::addr_t araddr_o,
  input wire logic           bad_speculation_o,
  input wire logic           prev_valid_i
);

  int fails = 0; // read by the testbench at the end of the run

  // ************************************************************
  // downstream handshake
  // ************************************************************
  // ready_o is the inverse of valid_o, so the two are never high together
  ready_inverts_valid: assert property (@(posedge clk) disable iff (rst) ready_o == !valid_o)
    else begin
      $error("ready_o is not the inverse of valid_o");
      fails++;
    end

  // no hand-over while a line is being refilled
  fetch_refill_excl: assert property (@(posedge clk) disable iff (rst) !(arvalid_o && valid_o))
    else begin
      $error("arvalid_o and valid_o are high in the same cycle");
      fails++;
    end

  // ************************************************************
  // bus and speculation
  // ************************************************************
  addr_aligned: assert property (@(posedge clk) disable iff (rst) araddr_o[1:0] == 2'b00)
    else begin
      $error("araddr_o is not word aligned");
      fails++;
    end

  bad_spec_needs_report: assert property (@(posedge clk) disable iff (rst)
    bad_speculation_o |-> prev_valid_i)
    else begin
      $error("bad_speculation_o without prev_valid_i");
      fails++;
    end

endmodule

bind ifu_top ifu_checker u_ifu_checker (
  .clk               (clk),
  .rst               (rst),
  .valid_o           (valid_o),
  .ready_o           (ready_o),
  .arvalid_o         (arvalid_o),
  .araddr_o          (araddr_o),
  .bad_speculation_o (bad_speculation_o),
  .prev_valid_i      (prev_valid_i)
);

`default_nettype wire

// File: tb/ifu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifu_params.svh"

module ifu_tb;

  localparam int MEM_WORDS = 64;
  localparam int LAST_IDX = 40; // the run ends with the transfer of this word
  // fewer than 50 transfers, each one under 80 cycles with refills and reports
  localparam int MAX_CYCLES = 50 * 80;
  localparam ifu_pkg::addr_t BASE = `IFU_PC_INIT;

  logic clk;
  logic rst;
  ifu_pkg::addr_t araddr_o;
  logic arvalid_o;
  ifu_pkg::inst_t rdata_i;
  logic rvalid_i;
  ifu_pkg::addr_t npc_i;
  logic prev_valid_i;
  logic pc_change_i;
  logic pc_retire_i;
  ifu_pkg::inst_t inst_o;
  ifu_pkg::addr_t pc_o;
  logic valid_o;
  logic ready_o;
  logic next_ready_i;
  logic bad_speculation_o;

  ifu_pkg::inst_t mem [MEM_WORDS];
  logic [15:0] lfsr_q;
  int mismatches, failures, cycles, bus_wait, rep_wait, jal_reports;
  ifu_pkg::addr_t req_addr, exp_pc, btb, spec_target, rep_npc, hold_pc;
  ifu_pkg::inst_t hold_inst;
  logic btb_valid, spec, stalled, rep_pending, rep_change, hold_valid;
  logic first_req_seen, need_req, done;
  ifu_pkg::addr_t cached_line [4]; // line numbers the cache should hold, per set
  logic [3:0] cached_valid;

  ifu_top u_ifu_top (
    .clk               (clk),
    .rst               (rst),
    .araddr_o          (araddr_o),
    .arvalid_o         (arvalid_o),
    .rdata_i           (rdata_i),
    .rvalid_i          (rvalid_i),
    .npc_i             (npc_i),
    .prev_valid_i      (prev_valid_i),
    .pc_change_i       (pc_change_i),
    .pc_retire_i       (pc_retire_i),
    .inst_o            (inst_o),
    .pc_o              (pc_o),
    .valid_o           (valid_o),
    .ready_o           (ready_o),
    .next_ready_i      (next_ready_i),
    .bad_speculation_o (bad_speculation_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ************************************************************
  // helpers
  // ************************************************************
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // taps 16,14,13,11
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val = {val[30:0], lfsr_q[0]};
    end
  endtask

  function automatic ifu_pkg::addr_t word_addr(input int n);
    return BASE + ifu_pkg::addr_t'(n * 4);
  endfunction

  function automatic int word_index(input ifu_pkg::addr_t a);
    return int'((a - BASE) >> 2);
  endfunction

  // kind of instruction placed at each word of the program
  function automatic logic [6:0] forced_opcode(input int idx);
    case (idx)
      3: return `IFU_OP_LOAD;
      6: return `IFU_OP_BRANCH;
      18: return `IFU_OP_JAL;
      23: return `IFU_OP_SYSTEM;
      default: return 7'b0010011;
    endcase
  endfunction

  task automatic expect_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("ERROR t=%0t %s", $time, msg);
    failures++;
  endtask

  // back end answer for the control instruction at word idx
  task automatic choose_report(input int idx);
    rep_change = 1'b1;
    case (idx)
      3: begin
        rep_change = 1'b0;
        rep_npc = word_addr(4);
      end
      6: rep_npc = word_addr(16);
      18: begin
        rep_npc = (jal_reports == 0) ? word_addr(16) : word_addr(20);
        jal_reports++;
      end
      23: rep_npc = word_addr(32);
      default: rep_npc = word_addr(idx + 1);
    endcase
  endtask

  // ************************************************************
  // bus model and back end, driven on the falling edge
  // ************************************************************
  task automatic bus_step();
    logic [31:0] d;
    int idx;
    if (rvalid_i) begin
      rvalid_i = 1'b0; // one-cycle response pulse
    end else if (arvalid_o) begin
      if (bus_wait < 0) begin
        draw_bits(2, d);
        bus_wait = 1 + int'(d % 3);
        req_addr = araddr_o;
      end else if (araddr_o !== req_addr) begin
        report_failure("read address changed while the request was held");
      end
      bus_wait--;
      if (bus_wait == 0) begin
        idx = word_index(req_addr);
        if (idx >= MEM_WORDS) begin
          report_failure("read request outside the program memory");
          rdata_i = '0;
        end else begin
          rdata_i = mem[idx];
        end
        rvalid_i = 1'b1;
        bus_wait = -1;
      end
    end
  endtask

  task automatic backend_step();
    logic [31:0] d;
    prev_valid_i = 1'b0;
    pc_change_i = 1'b0;
    pc_retire_i = 1'b0;
    if (rep_pending) begin
      next_ready_i = 1'b0; // nothing more is taken until the report
      if (rep_wait == 0) begin
        prev_valid_i = 1'b1;
        pc_change_i = rep_change;
        pc_retire_i = !rep_change;
        npc_i = rep_npc;
      end else begin
        rep_wait--;
      end
    end else begin
      draw_bits(2, d);
      next_ready_i = (d[1:0] != 2'b00);
    end
  endtask

  // ************************************************************
  // checks, sampled on the rising edge
  // ************************************************************
  task automatic sample_outputs();
    ifu_pkg::addr_t line;
    logic [31:0] d;
    logic [6:0] op;
    logic exp_bad;
    int idx;
    cycles++;
    line = araddr_o >> 3;
    if (arvalid_o) begin
      if (!first_req_seen) begin
        expect_value("araddr_o", araddr_o, BASE & ~ifu_pkg::addr_t'(7));
        first_req_seen = 1'b1;
      end
      need_req = 1'b0;
      if (cached_valid[line[1:0]] && cached_line[line[1:0]] == line) begin
        report_failure("bus request for a line that is already cached");
      end
      if (rvalid_i && araddr_o[2]) begin
        cached_line[line[1:0]] = line; // last beat completes the line
        cached_valid[line[1:0]] = 1'b1;
      end
    end
    if (stalled && valid_o) begin
      report_failure("instruction handed over while waiting on a report");
    end
    if (hold_valid) begin
      expect_value("pc_o", pc_o, hold_pc);
      expect_value("inst_o", inst_o, hold_inst);
    end
    hold_valid = valid_o && !next_ready_i && !prev_valid_i;
    hold_pc = pc_o;
    hold_inst = inst_o;
    if (valid_o && next_ready_i) begin
      idx = word_index(pc_o);
      expect_value("pc_o", pc_o, exp_pc);
      if (need_req) begin
        report_failure("no bus request between fence.i and the next transfer");
      end
      if (idx >= MEM_WORDS) begin
        report_failure("transfer from outside the program memory");
        done = 1'b1;
      end else begin
        expect_value("inst_o", inst_o, mem[idx]);
        op = mem[idx][6:0];
        if (idx == LAST_IDX) begin
          done = 1'b1;
        end
        if (mem[idx] == `IFU_INST_FENCE_I) begin
          need_req = 1'b1;
          cached_valid = '0;
          exp_pc = exp_pc + 4;
        end else if (op == `IFU_OP_JAL || op == `IFU_OP_JALR || op == `IFU_OP_BRANCH ||
                     op == `IFU_OP_SYSTEM || op == `IFU_OP_LOAD) begin
          if (op != `IFU_OP_LOAD && btb_valid && !spec) begin
            spec = 1'b1; // follows the last taken target
            spec_target = btb;
            exp_pc = btb;
          end else begin
            stalled = 1'b1;
          end
          choose_report(idx);
          draw_bits(2, d);
          rep_wait = 1 + int'(d[1:0]);
          rep_pending = 1'b1;
        end else begin
          exp_pc = exp_pc + 4;
        end
      end
    end
    if (prev_valid_i) begin
      exp_bad = spec && (npc_i != spec_target);
      expect_value("bad_speculation_o", 32'(bad_speculation_o), 32'(exp_bad));
      if (spec) begin
        if (exp_bad) begin
          exp_pc = npc_i;
        end
        spec = 1'b0;
      end else if (stalled) begin
        exp_pc = npc_i;
        stalled = 1'b0;
      end
      if (pc_change_i) begin
        btb = npc_i;
        btb_valid = 1'b1;
      end
      rep_pending = 1'b0;
    end else begin
      expect_value("bad_speculation_o", 32'(bad_speculation_o), 32'd0);
    end
  endtask

  // ************************************************************
  // main sequence
  // ************************************************************
  initial begin
    logic [31:0] w;
    int total;
    rst = 1'b1;
    rdata_i = '0;
    rvalid_i = 1'b0;
    npc_i = '0;
    prev_valid_i = 1'b0;
    pc_change_i = 1'b0;
    pc_retire_i = 1'b0;
    next_ready_i = 1'b1;
    lfsr_q = 16'd6473;
    {mismatches, failures, cycles, jal_reports} = '0;
    bus_wait = -1;
    rep_wait = 0;
    exp_pc = BASE;
    {btb, spec_target, rep_npc, hold_pc, req_addr} = '0;
    hold_inst = '0;
    {btb_valid, spec, stalled, rep_pending, rep_change, hold_valid} = '0;
    {first_req_seen, need_req, done} = '0;
    cached_valid = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      draw_bits(32, w);
      mem[i] = {w[31:7], forced_opcode(i)};
    end
    mem[20] = `IFU_INST_FENCE_I;

    repeat (3) @(posedge clk);
    expect_value("arvalid_o", 32'(arvalid_o), 32'd0);
    expect_value("valid_o", 32'(valid_o), 32'd0);
    expect_value("bad_speculation_o", 32'(bad_speculation_o), 32'd0);
    @(negedge clk);
    rst = 1'b0;

    while (!done && cycles < MAX_CYCLES) begin
      @(posedge clk);
      sample_outputs();
      @(negedge clk);
      bus_step();
      backend_step();
    end
    if (!done) begin
      report_failure("timeout, the program did not reach its last word");
    end
    if (!first_req_seen) begin
      report_failure("no bus request was ever made");
    end
    total = mismatches + failures + u_ifu_top.u_ifu_checker.fails;
    $display("mismatches: %0d, other errors: %0d, assertion failures: %0d",
             mismatches, failures, u_ifu_top.u_ifu_checker.fails);
    if (total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
